// File: src/lsu_pkg.sv
/* shared types for the load/store unit and its AXI4-Lite memory model;
   imported by every module that needs request, response or bus codes */
package lsu_pkg;

	// load kinds, none means the op does not read memory
	typedef enum logic [2:0] {
		LOAD_NONE = 3'd0,
		LOAD_LB   = 3'd1,
		LOAD_LH   = 3'd2,
		LOAD_LW   = 3'd3,
		LOAD_LBU  = 3'd4,
		LOAD_LHU  = 3'd5
	} load_type_e;

	// store kinds
	typedef enum logic [1:0] {
		STORE_NONE = 2'd0,
		STORE_SB   = 2'd1,
		STORE_SH   = 2'd2,
		STORE_SW   = 2'd3
	} store_type_e;

	// one memory request from execute
	typedef struct packed {
		logic [31:0] addr;       // effective address, or alu result
		logic [31:0] wdata;      // store data, unshifted
		load_type_e  load_type;
		store_type_e store_type;
		logic [4:0]  wreg;
		logic        wd;         // register write enable
	} lsu_req_t;

	// one writeback toward the register file
	typedef struct packed {
		logic [31:0] wdata;
		logic [4:0]  wreg;
		logic        wd;
		logic        err;        // bus returned a non-okay code
	} lsu_resp_t;

	// axi response codes
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	// axi size codes, log2 of bytes per beat
	localparam logic [2:0] AXI_SIZE_1 = 3'b000;
	localparam logic [2:0] AXI_SIZE_2 = 3'b001;
	localparam logic [2:0] AXI_SIZE_4 = 3'b010;

endpackage

// File: src/stage_slice.sv
/* one-entry valid/ready register slice for any payload type;
   full throughput, used on both the request and the response side */
`timescale 1ns/1ps

module stage_slice #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     in_valid_i,
	input  payload_t in_i,
	output logic     in_ready_o,
	output logic     out_valid_o,
	output payload_t out_o,
	input  logic     out_ready_i
);

	logic     valid_q;
	payload_t data_q;

	// accept when empty or when the held item leaves this cycle
	assign in_ready_o  = !valid_q || out_ready_i;
	assign out_valid_o = valid_q;
	assign out_o       = data_q;

	always_ff @(posedge clock) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else if (in_ready_o) begin
			valid_q <= in_valid_i;
		end
	end

	// payload only loads on a transfer
	always_ff @(posedge clock) begin
		if (in_valid_i && in_ready_o) begin
			data_q <= in_i;
		end
	end

	// downstream sees a stable item while it stalls
	out_stable: assert property (@(posedge clock) disable iff (!rstn)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule

// File: src/store_lane.sv
/* places store data and byte strobes on the lanes picked by the low
   address bits; also gives the AXI size of the store */
`timescale 1ns/1ps

module store_lane (
	input  logic [1:0]           offset_i,
	input  lsu_pkg::store_type_e store_type_i,
	input  logic [31:0]          wdata_i,
	output logic [31:0]          lane_data_o,
	output logic [3:0]           strb_o,
	output logic [2:0]           size_o
);
	import lsu_pkg::*;

	logic [3:0] base_strb;

	always_comb begin
		case (store_type_i)
			STORE_SB: begin
				base_strb = 4'b0001;
				size_o    = AXI_SIZE_1;
			end
			STORE_SH: begin
				base_strb = 4'b0011;
				size_o    = AXI_SIZE_2;
			end
			STORE_SW: begin
				base_strb = 4'b1111;
				size_o    = AXI_SIZE_4;
			end
			default: begin
				// no store, no lanes
				base_strb = 4'b0000;
				size_o    = AXI_SIZE_4;
			end
		endcase
	end

	// one byte of shift per offset step
	assign lane_data_o = wdata_i << {offset_i, 3'b000};
	assign strb_o      = base_strb << offset_i;

endmodule

// File: src/load_extend.sv
/* brings the addressed bytes of a read word down to bit 0 and
   sign- or zero-extends them according to the load kind */
`timescale 1ns/1ps

module load_extend (
	input  logic [1:0]          offset_i,
	input  lsu_pkg::load_type_e load_type_i,
	input  logic [31:0]         rdata_i,
	output logic [31:0]         value_o
);
	import lsu_pkg::*;

	logic [31:0] shifted;

	// addressed byte lands in bits 7:0
	assign shifted = rdata_i >> {offset_i, 3'b000};

	always_comb begin
		case (load_type_i)
			LOAD_LB: begin
				value_o = {{24{shifted[7]}}, shifted[7:0]};
			end
			LOAD_LH: begin
				value_o = {{16{shifted[15]}}, shifted[15:0]};
			end
			LOAD_LBU: begin
				value_o = {24'b0, shifted[7:0]};
			end
			LOAD_LHU: begin
				value_o = {16'b0, shifted[15:0]};
			end
			default: begin
				// lw, full word
				value_o = shifted;
			end
		endcase
	end

endmodule

// File: src/lsu_ctrl.sv
/* load/store control: takes one request at a time, runs it over AXI4-Lite
   and pushes the writeback; non-memory ops pass their address straight back */
`timescale 1ns/1ps

module lsu_ctrl (
	input  logic               clock,
	input  logic               rstn,
	// request side
	input  logic               req_valid_i,
	input  lsu_pkg::lsu_req_t  req_i,
	output logic               req_ready_o,
	// response side
	output logic               resp_valid_o,
	output lsu_pkg::lsu_resp_t resp_o,
	input  logic               resp_ready_i,
	// read address
	output logic [31:0]        ar_addr_o,
	output logic [2:0]         ar_size_o,
	output logic               ar_valid_o,
	input  logic               ar_ready_i,
	// read data
	input  logic [31:0]        r_data_i,
	input  logic [1:0]         r_resp_i,
	input  logic               r_valid_i,
	output logic               r_ready_o,
	// write address
	output logic [31:0]        aw_addr_o,
	output logic [2:0]         aw_size_o,
	output logic               aw_valid_o,
	input  logic               aw_ready_i,
	// write data
	output logic [31:0]        w_data_o,
	output logic [3:0]         w_strb_o,
	output logic               w_valid_o,
	input  logic               w_ready_i,
	// write response
	input  logic [1:0]         b_resp_i,
	input  logic               b_valid_i,
	output logic               b_ready_o
);
	import lsu_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_ADDR = 2'd1,
		ST_RESP = 2'd2,
		ST_DONE = 2'd3
	} state_e;

	state_e      state_q;
	state_e      state_d;
	lsu_req_t    req_q;
	logic        is_load;
	logic        is_store;
	logic        req_fire;
	logic        ar_fire;
	logic        aw_fire;
	logic        w_fire;
	logic        r_fire;
	logic        b_fire;
	logic        aw_done_q;
	logic        w_done_q;
	logic [31:0] load_value;
	logic [31:0] resp_data_q;
	logic        resp_err_q;

	// a load wins if both kinds are set
	assign is_load  = req_q.load_type != LOAD_NONE;
	assign is_store = req_q.store_type != STORE_NONE && !is_load;

	assign req_ready_o = state_q == ST_IDLE;
	assign req_fire    = req_valid_i && req_ready_o;
	assign ar_fire     = ar_valid_o && ar_ready_i;
	assign aw_fire     = aw_valid_o && aw_ready_i;
	assign w_fire      = w_valid_o && w_ready_i;
	assign r_fire      = r_valid_i && r_ready_o;
	assign b_fire      = b_valid_i && b_ready_o;

	// channel valids, aw and w drop independently
	assign ar_valid_o = state_q == ST_ADDR && is_load;
	assign aw_valid_o = state_q == ST_ADDR && is_store && !aw_done_q;
	assign w_valid_o  = state_q == ST_ADDR && is_store && !w_done_q;
	assign r_ready_o  = state_q == ST_RESP && is_load;
	assign b_ready_o  = state_q == ST_RESP && is_store;

	assign ar_addr_o = req_q.addr;
	assign aw_addr_o = req_q.addr;

	always_comb begin
		case (req_q.load_type)
			LOAD_LB, LOAD_LBU: ar_size_o = AXI_SIZE_1;
			LOAD_LH, LOAD_LHU: ar_size_o = AXI_SIZE_2;
			default:           ar_size_o = AXI_SIZE_4;
		endcase
	end

	// store lanes from the captured address
	store_lane u_store_lane (
		.offset_i     (req_q.addr[1:0]),
		.store_type_i (req_q.store_type),
		.wdata_i      (req_q.wdata),
		.lane_data_o  (w_data_o),
		.strb_o       (w_strb_o),
		.size_o       (aw_size_o)
	);

	// read data back to bit 0 and extended
	load_extend u_load_extend (
		.offset_i    (req_q.addr[1:0]),
		.load_type_i (req_q.load_type),
		.rdata_i     (r_data_i),
		.value_o     (load_value)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req_fire) begin
					if (req_i.load_type != LOAD_NONE || req_i.store_type != STORE_NONE) begin
						state_d = ST_ADDR;
					end else begin
						state_d = ST_DONE;
					end
				end
			end
			ST_ADDR: begin
				// store needs both aw and w, now or earlier
				if (ar_fire || ((aw_done_q || aw_fire) && (w_done_q || w_fire))) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				if (r_fire || b_fire) begin
					state_d = ST_DONE;
				end
			end
			default: begin
				if (resp_ready_i) begin
					state_d = ST_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q   <= ST_IDLE;
			aw_done_q <= 1'b0;
			w_done_q  <= 1'b0;
		end else begin
			state_q   <= state_d;
			// completion bits live only while in addr
			aw_done_q <= state_d == ST_ADDR && (aw_done_q || aw_fire);
			w_done_q  <= state_d == ST_ADDR && (w_done_q || w_fire);
		end
	end

	// request capture and writeback value
	always_ff @(posedge clock) begin
		if (req_fire) begin
			req_q       <= req_i;
			resp_data_q <= req_i.addr;
			resp_err_q  <= 1'b0;
		end
		if (r_fire) begin
			resp_data_q <= load_value;
			resp_err_q  <= r_resp_i != AXI_RESP_OKAY;
		end
		if (b_fire) begin
			resp_data_q <= '0;
			resp_err_q  <= b_resp_i != AXI_RESP_OKAY;
		end
	end

	assign resp_valid_o = state_q == ST_DONE;
	assign resp_o       = '{wdata: resp_data_q, wreg: req_q.wreg, wd: req_q.wd, err: resp_err_q};

	// a raised channel stays up with the same address until the slave takes it
	ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));
	aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));
	w_hold: assert property (@(posedge clock) disable iff (!rstn)
		w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o));

endmodule

// File: src/axi_lite_ram.sv
/* word-organised AXI4-Lite slave memory; one access at a time,
   R or B after a fixed latency, SLVERR past the last word */
`timescale 1ns/1ps

module axi_lite_ram #(
	parameter int RAM_WORDS   = 256,
	parameter int RAM_LATENCY = 2
) (
	input  logic        clock,
	input  logic        rstn,
	input  logic [31:0] ar_addr_i,
	input  logic [2:0]  ar_size_i,
	input  logic        ar_valid_i,
	output logic        ar_ready_o,
	output logic [31:0] r_data_o,
	output logic [1:0]  r_resp_o,
	output logic        r_valid_o,
	input  logic        r_ready_i,
	input  logic [31:0] aw_addr_i,
	input  logic [2:0]  aw_size_i,
	input  logic        aw_valid_i,
	output logic        aw_ready_o,
	input  logic [31:0] w_data_i,
	input  logic [3:0]  w_strb_i,
	input  logic        w_valid_i,
	output logic        w_ready_o,
	output logic [1:0]  b_resp_o,
	output logic        b_valid_o,
	input  logic        b_ready_i
);
	import lsu_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam int CNT_W = $clog2(RAM_LATENCY + 1);

	logic [31:0]      mem [RAM_WORDS];
	logic             busy_q;
	logic             resp_valid_q;
	logic             is_read_q;
	logic [CNT_W-1:0] cnt_q;
	logic [31:0]      rdata_q;
	logic [1:0]       resp_q;
	logic             ar_fire;
	logic             aw_fire;
	logic             ar_ok;
	logic             aw_ok;
	logic [IDX_W-1:0] ar_idx;
	logic [IDX_W-1:0] aw_idx;
	logic [3:0]       rd_mask;
	logic [3:0]       wr_mask;
	logic [31:0]      rd_word;

	// bytes covered by one sized beat
	function automatic logic [3:0] lane_mask(input logic [1:0] off, input logic [2:0] size);
		logic [3:0] base;
		case (size)
			AXI_SIZE_1: base = 4'b0001;
			AXI_SIZE_2: base = 4'b0011;
			default:    base = 4'b1111;
		endcase
		return base << off;
	endfunction

	assign ar_ready_o = !busy_q;
	assign aw_ready_o = !busy_q;
	assign w_ready_o  = !busy_q;
	assign ar_fire    = ar_valid_i && ar_ready_o;
	assign aw_fire    = aw_valid_i && aw_ready_o;

	// word index and range check
	assign ar_ok   = ar_addr_i[31:2] < RAM_WORDS;
	assign aw_ok   = aw_addr_i[31:2] < RAM_WORDS;
	assign ar_idx  = ar_addr_i[IDX_W+1:2];
	assign aw_idx  = aw_addr_i[IDX_W+1:2];
	assign rd_mask = lane_mask(ar_addr_i[1:0], ar_size_i);
	assign wr_mask = w_strb_i & lane_mask(aw_addr_i[1:0], aw_size_i);

	// only the sized bytes come back
	always_comb begin
		rd_word = '0;
		for (int b = 0; b < 4; b++) begin
			if (rd_mask[b]) begin
				rd_word[8*b +: 8] = mem[ar_idx][8*b +: 8];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			busy_q       <= 1'b0;
			resp_valid_q <= 1'b0;
			cnt_q        <= '0;
		end else if (!busy_q) begin
			if (ar_fire || aw_fire) begin
				busy_q <= 1'b1;
				cnt_q  <= CNT_W'(RAM_LATENCY);
			end
		end else if (resp_valid_q) begin
			if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
				busy_q       <= 1'b0;
				resp_valid_q <= 1'b0;
			end
		end else begin
			// last count raises the response
			cnt_q <= cnt_q - 1'b1;
			if (cnt_q == CNT_W'(1)) begin
				resp_valid_q <= 1'b1;
			end
		end
	end

	// response payload, read data sampled at the address handshake
	always_ff @(posedge clock) begin
		if (ar_fire) begin
			is_read_q <= 1'b1;
			rdata_q   <= ar_ok ? rd_word : '0;
			resp_q    <= ar_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end else if (aw_fire) begin
			is_read_q <= 1'b0;
			resp_q    <= aw_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end
	end

	// strobed byte writes, dropped when out of range
	always_ff @(posedge clock) begin
		if (aw_fire && aw_ok) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_mask[b]) begin
					mem[aw_idx][8*b +: 8] <= w_data_i[8*b +: 8];
				end
			end
		end
	end

	assign r_valid_o = resp_valid_q && is_read_q;
	assign b_valid_o = resp_valid_q && !is_read_q;
	assign r_data_o  = rdata_q;
	assign r_resp_o  = resp_q;
	assign b_resp_o  = resp_q;

	// write data is taken with its address, never alone
	aw_w_paired: assert property (@(posedge clock) disable iff (!rstn)
		aw_fire == (w_valid_i && w_ready_o));

endmodule

// File: src/lsu_top.sv
/* load/store unit top: request slice, control, response slice and
   the AXI4-Lite memory model, driven from one request and one response port */
`timescale 1ns/1ps

module lsu_top #(
	parameter int RAM_WORDS   = 256,
	parameter int RAM_LATENCY = 2
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               req_valid_i,
	output logic               req_ready_o,
	input  lsu_pkg::lsu_req_t  req_i,
	output logic               resp_valid_o,
	input  logic               resp_ready_i,
	output lsu_pkg::lsu_resp_t resp_o
);
	import lsu_pkg::*;

	lsu_req_t    ctrl_req;
	lsu_resp_t   ctrl_resp;
	logic        ctrl_req_valid;
	logic        ctrl_req_ready;
	logic        ctrl_resp_valid;
	logic        ctrl_resp_ready;
	logic [31:0] ar_addr;
	logic [31:0] aw_addr;
	logic [31:0] w_data;
	logic [31:0] r_data;
	logic [2:0]  ar_size;
	logic [2:0]  aw_size;
	logic [3:0]  w_strb;
	logic [1:0]  r_resp;
	logic [1:0]  b_resp;
	logic        ar_valid;
	logic        ar_ready;
	logic        aw_valid;
	logic        aw_ready;
	logic        w_valid;
	logic        w_ready;
	logic        r_valid;
	logic        r_ready;
	logic        b_valid;
	logic        b_ready;

	// request side register
	stage_slice #(.payload_t(lsu_req_t)) u_req_slice (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid_i  (req_valid_i),
		.in_i        (req_i),
		.in_ready_o  (req_ready_o),
		.out_valid_o (ctrl_req_valid),
		.out_o       (ctrl_req),
		.out_ready_i (ctrl_req_ready)
	);

	lsu_ctrl u_ctrl (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (ctrl_req_valid),
		.req_i        (ctrl_req),
		.req_ready_o  (ctrl_req_ready),
		.resp_valid_o (ctrl_resp_valid),
		.resp_o       (ctrl_resp),
		.resp_ready_i (ctrl_resp_ready),
		.ar_addr_o    (ar_addr),
		.ar_size_o    (ar_size),
		.ar_valid_o   (ar_valid),
		.ar_ready_i   (ar_ready),
		.r_data_i     (r_data),
		.r_resp_i     (r_resp),
		.r_valid_i    (r_valid),
		.r_ready_o    (r_ready),
		.aw_addr_o    (aw_addr),
		.aw_size_o    (aw_size),
		.aw_valid_o   (aw_valid),
		.aw_ready_i   (aw_ready),
		.w_data_o     (w_data),
		.w_strb_o     (w_strb),
		.w_valid_o    (w_valid),
		.w_ready_i    (w_ready),
		.b_resp_i     (b_resp),
		.b_valid_i    (b_valid),
		.b_ready_o    (b_ready)
	);

	// response side register
	stage_slice #(.payload_t(lsu_resp_t)) u_resp_slice (
		.clock       (clock),
		.rstn        (rstn),
		.in_valid_i  (ctrl_resp_valid),
		.in_i        (ctrl_resp),
		.in_ready_o  (ctrl_resp_ready),
		.out_valid_o (resp_valid_o),
		.out_o       (resp_o),
		.out_ready_i (resp_ready_i)
	);

	axi_lite_ram #(
		.RAM_WORDS   (RAM_WORDS),
		.RAM_LATENCY (RAM_LATENCY)
	) u_ram (
		.clock      (clock),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_size_i  (ar_size),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.r_data_o   (r_data),
		.r_resp_o   (r_resp),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.aw_addr_i  (aw_addr),
		.aw_size_i  (aw_size),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

endmodule

// File: verif/lsu_tb_table.svh
/* directed request table for lsu_tb, included in the testbench module body;
   one add_row call per request, applied in order by the table loop */
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

	task automatic build_table();
		// columns: load, store, addr, wdata, wreg, wd, expected value, expected err
		// word store, word load, pass-through
		add_row(LOAD_NONE, STORE_SW,   'h00000010, 'hdeadbeef, 0,  0, 'h00000000, 0);
		add_row(LOAD_LW,   STORE_NONE, 'h00000010, 'h00000000, 5,  1, 'hdeadbeef, 0);
		add_row(LOAD_NONE, STORE_NONE, 'h12345678, 'h0bad0bad, 7,  1, 'h12345678, 0);
		add_row(LOAD_NONE, STORE_NONE, 'hfffffffc, 'h00000000, 31, 0, 'hfffffffc, 0);
		// byte lanes of word 0x20
		add_row(LOAD_NONE, STORE_SW,   'h00000020, 'h11223344, 1,  0, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SB,   'h00000020, 'hffffffaa, 2,  1, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SB,   'h00000021, 'h000000bb, 2,  0, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SB,   'h00000022, 'h12345680, 4,  0, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SB,   'h00000023, 'h0000007f, 6,  1, 'h00000000, 0);
		add_row(LOAD_LW,   STORE_NONE, 'h00000020, 'h00000000, 8,  1, 'h7f80bbaa, 0);
		add_row(LOAD_LB,   STORE_NONE, 'h00000020, 'h00000000, 9,  1, 'hffffffaa, 0);
		add_row(LOAD_LBU,  STORE_NONE, 'h00000021, 'h00000000, 10, 1, 'h000000bb, 0);
		add_row(LOAD_LB,   STORE_NONE, 'h00000022, 'h00000000, 11, 1, 'hffffff80, 0);
		add_row(LOAD_LB,   STORE_NONE, 'h00000023, 'h00000000, 12, 0, 'h0000007f, 0);
		add_row(LOAD_LBU,  STORE_NONE, 'h00000022, 'h00000000, 13, 1, 'h00000080, 0);
		add_row(LOAD_LH,   STORE_NONE, 'h00000020, 'h00000000, 14, 1, 'hffffbbaa, 0);
		add_row(LOAD_LHU,  STORE_NONE, 'h00000022, 'h00000000, 15, 1, 'h00007f80, 0);
		// halfword lanes of word 0x30
		add_row(LOAD_NONE, STORE_SW,   'h00000030, 'h00000000, 0,  0, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SH,   'h00000030, 'hffff8001, 0,  0, 'h00000000, 0);
		add_row(LOAD_NONE, STORE_SH,   'h00000032, 'haaaa1234, 0,  0, 'h00000000, 0);
		add_row(LOAD_LH,   STORE_NONE, 'h00000030, 'h00000000, 16, 1, 'hffff8001, 0);
		add_row(LOAD_LHU,  STORE_NONE, 'h00000030, 'h00000000, 17, 1, 'h00008001, 0);
		add_row(LOAD_LH,   STORE_NONE, 'h00000032, 'h00000000, 18, 1, 'h00001234, 0);
		add_row(LOAD_LHU,  STORE_NONE, 'h00000032, 'h00000000, 19, 0, 'h00001234, 0);
		add_row(LOAD_LW,   STORE_NONE, 'h00000030, 'h00000000, 20, 1, 'h12348001, 0);
		// past the last word, 0x400 would alias word 0 if it were written
		add_row(LOAD_NONE, STORE_SW,   'h00000000, 'hcafef00d, 0,  0, 'h00000000, 0);
		add_row(LOAD_LW,   STORE_NONE, 'h00000400, 'h00000000, 3,  1, 'h00000000, 1);
		add_row(LOAD_LBU,  STORE_NONE, 'h80000001, 'h00000000, 4,  1, 'h00000000, 1);
		add_row(LOAD_NONE, STORE_SW,   'h00000400, 'h55555555, 0,  0, 'h00000000, 1);
		add_row(LOAD_NONE, STORE_SB,   'h00000401, 'h00000066, 0,  1, 'h00000000, 1);
		add_row(LOAD_LW,   STORE_NONE, 'h00000000, 'h00000000, 21, 1, 'hcafef00d, 0);
	endtask

`endif

// File: verif/lsu_tb.sv
/* testbench for lsu_top: a directed table of loads and stores, then a random
   word stream with response back-pressure, checked against a byte model */
`timescale 1ns/1ps

module lsu_tb;
	import lsu_pkg::*;

	localparam int RAM_WORDS   = 256;
	localparam int RAM_LATENCY = 2;
	localparam int WAIT_LIMIT  = 100;
	localparam int RAND_OPS    = 60;
	localparam int QUIET_TIME  = 25;

	// one table row, request plus expected writeback
	typedef struct packed {
		lsu_req_t    req;
		logic [31:0] exp_data;
		logic        exp_err;
	} row_t;

	logic      clock;
	logic      rstn;
	logic      req_valid_i;
	logic      req_ready_o;
	lsu_req_t  req_i;
	logic      resp_valid_o;
	logic      resp_ready_i;
	lsu_resp_t resp_o;

	int        seed;
	row_t      rows[$];
	lsu_resp_t pending[$];
	logic [7:0] ref_mem [RAM_WORDS*4];
	bit        written [8];

	lsu_top #(
		.RAM_WORDS   (RAM_WORDS),
		.RAM_LATENCY (RAM_LATENCY)
	) uut (
		.clock        (clock),
		.rstn         (rstn),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.req_i        (req_i),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i),
		.resp_o       (resp_o)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic add_row(input load_type_e lt, input store_type_e st,
			input logic [31:0] addr, input logic [31:0] wdata, input int wreg,
			input int wd, input logic [31:0] exp_data, input int exp_err);
		row_t row;
		row.req            = '0;
		row.req.load_type  = lt;
		row.req.store_type = st;
		row.req.addr       = addr;
		row.req.wdata      = wdata;
		row.req.wreg       = 5'(wreg);
		row.req.wd         = wd != 0;
		row.exp_data       = exp_data;
		row.exp_err        = exp_err != 0;
		rows.push_back(row);
	endtask

	`include "lsu_tb_table.svh"

	// byte model, one call per request in issue order
	task automatic model_step(input lsu_req_t r, output lsu_resp_t want);
		logic in_range;
		int   a;
		in_range   = r.addr[31:2] < RAM_WORDS;
		a          = int'(r.addr[11:0]);
		want.wreg  = r.wreg;
		want.wd    = r.wd;
		want.err   = 1'b0;
		want.wdata = r.addr;
		if (r.load_type != LOAD_NONE) begin
			want.err   = !in_range;
			want.wdata = '0;
			if (in_range) begin
				case (r.load_type)
					LOAD_LB:  want.wdata = {{24{ref_mem[a][7]}}, ref_mem[a]};
					LOAD_LBU: want.wdata = {24'h0, ref_mem[a]};
					LOAD_LH:  want.wdata = {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
					LOAD_LHU: want.wdata = {16'h0, ref_mem[a+1], ref_mem[a]};
					default:  want.wdata = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
				endcase
			end
		end else if (r.store_type != STORE_NONE) begin
			// stores write back zero, out of range leaves memory alone
			want.err   = !in_range;
			want.wdata = '0;
			if (in_range) begin
				ref_mem[a] = r.wdata[7:0];
				if (r.store_type != STORE_SB) begin
					ref_mem[a+1] = r.wdata[15:8];
				end
				if (r.store_type == STORE_SW) begin
					ref_mem[a+2] = r.wdata[23:16];
					ref_mem[a+3] = r.wdata[31:24];
				end
			end
		end
	endtask

	task automatic compare_resp(input lsu_resp_t got, input lsu_resp_t want);
		check_value("resp_o.wdata", got.wdata, want.wdata);
		check_value("resp_o.wreg", 32'(got.wreg), 32'(want.wreg));
		check_value("resp_o.wd", 32'(got.wd), 32'(want.wd));
		check_value("resp_o.err", 32'(got.err), 32'(want.err));
	endtask

	// ten reset edges, idle outputs checked on each falling edge
	task automatic reset_dut();
		for (int i = 0; i < 12; i++) begin
			@(posedge clock);
			if (i == 9) begin
				rstn <= 1'b1;
			end
			@(negedge clock);
			check_value("resp_valid_o", 32'(resp_valid_o), 32'h0);
			check_value("req_ready_o", 32'(req_ready_o), 32'h1);
		end
	endtask

	// returns just after the edge that took the request
	task automatic send_req(input lsu_req_t r);
		int waited;
		@(posedge clock);
		req_valid_i <= 1'b1;
		req_i       <= r;
		waited = 0;
		@(negedge clock);
		while (!req_ready_o) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run("request handshake never came, req_ready_o stayed low");
			end
			@(negedge clock);
		end
		@(posedge clock);
		req_valid_i <= 1'b0;
	endtask

	// resp_ready_i is high here, so valid means taken at the next edge
	task automatic take_resp(output lsu_resp_t got);
		int waited;
		waited = 0;
		@(negedge clock);
		while (!resp_valid_o) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				abort_run("response handshake never came, resp_valid_o stayed low");
			end
			@(negedge clock);
		end
		got = resp_o;
		@(posedge clock);
	endtask

	task automatic run_table();
		lsu_resp_t got;
		lsu_resp_t want;
		foreach (rows[i]) begin
			model_step(rows[i].req, want);
			send_req(rows[i].req);
			take_resp(got);
			check_value("resp_o.wdata", got.wdata, rows[i].exp_data);
			check_value("resp_o.err", 32'(got.err), 32'(rows[i].exp_err));
			compare_resp(got, want);
		end
	endtask

	// random word traffic on words 0x40..0x47, loads only after a store
	task automatic stream_requests();
		lsu_req_t  r;
		lsu_resp_t want;
		int        w;
		for (int n = 0; n < RAND_OPS; n++) begin
			w      = $random(seed) & 7;
			r      = '0;
			r.addr = 32'h100 + 32'(w * 4);
			r.wreg = 5'($random(seed));
			r.wd   = ($random(seed) & 1) != 0;
			if (!written[w] || (($random(seed) & 1) != 0)) begin
				r.store_type = STORE_SW;
				r.wdata      = $random(seed);
				written[w]   = 1'b1;
			end else begin
				r.load_type = LOAD_LW;
			end
			model_step(r, want);
			pending.push_back(want);
			send_req(r);
		end
	endtask

	// random resp_ready_i, checks each taken response in order
	task automatic drain_responses();
		lsu_resp_t want;
		int        got_count;
		int        idle;
		got_count = 0;
		idle      = 0;
		while (got_count < RAND_OPS) begin
			@(posedge clock);
			resp_ready_i <= ($random(seed) & 1) != 0;
			@(negedge clock);
			if (resp_valid_o && resp_ready_i) begin
				if (pending.size() == 0) begin
					abort_run("a response came back with no request outstanding");
				end
				want = pending.pop_front();
				compare_resp(resp_o, want);
				got_count++;
				idle = 0;
			end else begin
				idle++;
				if (idle > WAIT_LIMIT) begin
					abort_run("random phase stalled, no response handshake for too long");
				end
			end
		end
	endtask

	// every request is answered by now, so the output must stay quiet
	task automatic run_random(output int stray);
		stray = 0;
		fork
			stream_requests();
			drain_responses();
		join
		@(posedge clock);
		resp_ready_i <= 1'b1;
		for (int i = 0; i < QUIET_TIME; i++) begin
			@(negedge clock);
			if (resp_valid_o) begin
				stray++;
			end
			@(posedge clock);
		end
	endtask

	initial begin
		int stray;
		seed         = 16221;
		rstn         = 1'b0;
		req_valid_i  = 1'b0;
		req_i        = '0;
		resp_ready_i = 1'b1;
		build_table();
		reset_dut();
		run_table();
		run_random(stray);
		if (stray != 0) begin
			abort_run($sformatf("%0d extra responses came back after the last request", stray));
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+verif
src/lsu_pkg.sv
src/stage_slice.sv
src/store_lane.sv
src/load_extend.sv
src/lsu_ctrl.sv
src/axi_lite_ram.sv
src/lsu_top.sv
verif/lsu_tb.sv

// File: Makefile
# Verilator flow for the load/store unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f list.f --top-module lsu_tb -Mdir obj_dir

# pass only when the run printed the pass line
run: compile
	@out=$$(./obj_dir/Vlsu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
